/* src/dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address and data widths
`define DC_ADDR_W 32
`define DC_XLEN 64

// set geometry
`define DC_SETS 64
`define DC_INDEX_W 6
`define DC_OFFSET_W 5
`define DC_TAG_W 21

// line made of 64-bit beats, word 0 first
`define DC_BEATS 4
`define DC_LINE_W 256

// associativity
`define DC_WAYS 2

`endif

/* src/cachePkg.sv */
`default_nettype none
`include "dcache_consts.svh"

package cachePkg;

  // address fields, tag on top, byte offset at the bottom
  typedef logic [`DC_ADDR_W-1:0] addrT;
  typedef logic [`DC_TAG_W-1:0] tagT;
  typedef logic [`DC_INDEX_W-1:0] indexT;
  typedef logic [$clog2(`DC_BEATS)-1:0] wordSelT;

  // one bit per way
  typedef logic [`DC_WAYS-1:0] wayVecT;

  // controller FSM
  typedef enum logic [2:0] {
    idle,
    lookup,
    writeBack,
    refillReq,
    refillData,
    refill
  } ctrlStateT;

endpackage

`default_nettype wire

/* src/busPkg.sv */
`default_nettype none
`include "dcache_consts.svh"

package busPkg;

  // one data word, also one bus beat
  typedef logic [`DC_XLEN-1:0] wordT;

  // byte enables of a word
  typedef logic [`DC_XLEN/8-1:0] byteMaskT;

  // full cache line, word 0 in the low bits
  typedef logic [`DC_LINE_W-1:0] lineT;

endpackage

`default_nettype wire

/* src/cacheCtrl.sv */
`default_nettype none
`include "dcache_consts.svh"

module cacheCtrl
  import cachePkg::*, busPkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  // cpu request
  input  wire       reqValid_i,
  input  wire       reqWrite_i,
  input  wire addrT addr_i,
  input  wire wordT wrData_i,
  input  wire byteMaskT wrMask_i,
  // lookup results from the way merger
  input  wire       anyHit_i,
  input  wire wayVecT hitVec_i,
  input  wire       victimDirty_i,
  input  wire tagT  victimTag_i,
  input  wire lineT victimLine_i,
  // bus side
  input  wire       rdGnt_i,
  input  wire       rdBeatValid_i,
  input  wire       rdLast_i,
  input  wire wordT rdBeat_i,
  input  wire       wrGnt_i,
  output logic      ready_o,
  output logic      rdValid_o,
  // way control
  output indexT     index_o,
  output tagT       tag_o,
  output wordSelT   wordSel_o,
  output logic      victimWay_o,
  output wayVecT    storeEn_o,
  output wayVecT    fillEn_o,
  output wordT      storeWord_o,
  output byteMaskT  storeMask_o,
  output lineT      fillLine_o,
  // bus requests
  output logic      rdReq_o,
  output addrT      rdAddr_o,
  output logic      wrReq_o,
  output addrT      wrAddr_o,
  output lineT      wrLine_o
);

  localparam int wordLsb = $clog2(`DC_XLEN / 8);

  ctrlStateT state;
  ctrlStateT nextState;

  // accepted request
  addrT     reqAddr;
  logic     reqWrite;
  wordT     reqData;
  byteMaskT reqMask;
  indexT    reqIndex;
  tagT      reqTag;

  logic     victimToggle;
  logic     victimReg;
  wordSelT  beatCnt;
  lineT     refillBuf;

  assign reqIndex = reqAddr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign reqTag = reqAddr[`DC_ADDR_W-1 -: `DC_TAG_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (reqValid_i) begin
          nextState = lookup;
        end
      end
      lookup: begin
        if (anyHit_i) begin
          nextState = idle;
        end else if (victimDirty_i) begin
          nextState = writeBack;
        end else begin
          nextState = refillReq;
        end
      end
      writeBack: begin
        if (wrGnt_i) begin
          nextState = refillReq;
        end
      end
      refillReq: begin
        if (rdGnt_i) begin
          nextState = refillData;
        end
      end
      refillData: begin
        if (rdBeatValid_i && rdLast_i) begin
          nextState = refill;
        end
      end
      refill: begin
        // retry the lookup that now hits
        nextState = lookup;
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == idle && reqValid_i) begin
      reqAddr <= addr_i;
      reqWrite <= reqWrite_i;
      reqData <= wrData_i;
      reqMask <= wrMask_i;
    end
  end

  // victim is the toggle value at the missing lookup
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimToggle <= 1'b0;
      victimReg <= 1'b0;
    end else if (state == lookup && !anyHit_i) begin
      victimReg <= victimToggle;
      victimToggle <= ~victimToggle;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (state == refillReq) begin
      beatCnt <= '0;
    end else if (state == refillData && rdBeatValid_i) begin
      beatCnt <= beatCnt + wordSelT'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (state == refillData && rdBeatValid_i) begin
      refillBuf[beatCnt*`DC_XLEN +: `DC_XLEN] <= rdBeat_i;
    end
  end

  assign ready_o = (state == idle);
  assign rdValid_o = (state == lookup) && anyHit_i && !reqWrite;

  assign index_o = reqIndex;
  assign tag_o = reqTag;
  assign wordSel_o = reqAddr[wordLsb +: $bits(wordSelT)];
  // merger needs the victim already during the missing lookup
  assign victimWay_o = (state == lookup) ? victimToggle : victimReg;

  assign storeEn_o = (state == lookup && anyHit_i && reqWrite) ? hitVec_i : '0;
  assign fillEn_o = (state == refill) ? (wayVecT'(1) << victimReg) : '0;
  assign storeWord_o = reqData;
  assign storeMask_o = reqMask;
  assign fillLine_o = refillBuf;

  assign rdReq_o = (state == refillReq);
  assign rdAddr_o = {reqTag, reqIndex, {`DC_OFFSET_W{1'b0}}};
  assign wrReq_o = (state == writeBack);
  assign wrAddr_o = {victimTag_i, reqIndex, {`DC_OFFSET_W{1'b0}}};
  assign wrLine_o = victimLine_i;

  // grants only answer a pending request
  assert property (@(posedge clk) disable iff (!rst_n)
    (!rdGnt_i || rdReq_o) && (!wrGnt_i || wrReq_o))
    else $error("bus grant without a pending request");

  // beats only after the read grant
  assert property (@(posedge clk) disable iff (!rst_n)
    rdBeatValid_i |-> state == refillData)
    else $error("refill beat outside refillData");

endmodule

`default_nettype wire

/* src/cacheWay.sv */
`default_nettype none
`include "dcache_consts.svh"

module cacheWay
  import cachePkg::*, busPkg::*;
(
  input  wire          clk,
  input  wire          rst_n,
  input  wire indexT   index_i,
  input  wire tagT     tag_i,
  input  wire wordSelT wordSel_i,
  // store hit path
  input  wire          storeEn_i,
  input  wire wordT    storeWord_i,
  input  wire byteMaskT storeMask_i,
  // refill path
  input  wire          fillEn_i,
  input  wire lineT    fillLine_i,
  output logic         hit_o,
  output lineT         line_o,
  output tagT          tag_o,
  output logic         dirty_o
);

  logic [`DC_SETS-1:0] validBits;
  logic [`DC_SETS-1:0] dirtyBits;
  tagT  tagArr [`DC_SETS];
  lineT lineArr [`DC_SETS];

  wordT oldWord;
  wordT mergedWord;

  assign line_o = lineArr[index_i];
  assign tag_o = tagArr[index_i];
  assign dirty_o = dirtyBits[index_i];
  assign hit_o = validBits[index_i] && (tagArr[index_i] == tag_i);

  // byte merge into the addressed word
  assign oldWord = line_o[wordSel_i*`DC_XLEN +: `DC_XLEN];

  always_comb begin
    mergedWord = oldWord;
    for (int b = 0; b < `DC_XLEN / 8; b++) begin
      if (storeMask_i[b]) begin
        mergedWord[b*8 +: 8] = storeWord_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      lineArr[index_i] <= fillLine_i;
      tagArr[index_i] <= tag_i;
    end else if (storeEn_i) begin
      lineArr[index_i][wordSel_i*`DC_XLEN +: `DC_XLEN] <= mergedWord;
    end
  end

  // fill brings a clean line, a store makes it dirty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (fillEn_i) begin
      validBits[index_i] <= 1'b1;
      dirtyBits[index_i] <= 1'b0;
    end else if (storeEn_i) begin
      dirtyBits[index_i] <= 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(storeEn_i && fillEn_i))
    else $error("store and fill hit the same way together");

endmodule

`default_nettype wire

/* src/wayMerge.sv */
`default_nettype none
`include "dcache_consts.svh"

module wayMerge
  import cachePkg::*, busPkg::*;
(
  input  wire wayVecT               hitVec_i,
  input  wire lineT [`DC_WAYS-1:0]  lines_i,
  input  wire tagT [`DC_WAYS-1:0]   tags_i,
  input  wire wayVecT               dirtyBits_i,
  input  wire                       victimWay_i,
  input  wire wordSelT              wordSel_i,
  output wayVecT                    hitVec_o,
  output logic                      anyHit_o,
  output wordT                      rdData_o,
  output logic                      victimDirty_o,
  output tagT                       victimTag_o,
  output lineT                      victimLine_o
);

  lineT hitLine;

  // and-or select of the hitting line
  always_comb begin
    hitLine = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (hitVec_i[w]) begin
        hitLine = hitLine | lines_i[w];
      end
    end
  end

  assign hitVec_o = hitVec_i;
  assign anyHit_o = |hitVec_i;
  assign rdData_o = hitLine[wordSel_i*`DC_XLEN +: `DC_XLEN];

  // eviction candidate
  assign victimDirty_o = dirtyBits_i[victimWay_i];
  assign victimTag_o = tags_i[victimWay_i];
  assign victimLine_o = lines_i[victimWay_i];

  // a line lives in one way only
  always_comb begin
    assert final ($onehot0(hitVec_i))
      else $error("more than one way hits");
  end

endmodule

`default_nettype wire

/* src/dcacheTop.sv */
`default_nettype none
`include "dcache_consts.svh"

module dcacheTop
  import cachePkg::*, busPkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  // cpu side
  input  wire           reqValid_i,
  input  wire           reqWrite_i,
  input  wire addrT     addr_i,
  input  wire wordT     wrData_i,
  input  wire byteMaskT wrMask_i,
  output logic          ready_o,
  output logic          rdValid_o,
  output wordT          rdData_o,
  // bus read side
  output logic          rdReq_o,
  output addrT          rdAddr_o,
  input  wire           rdGnt_i,
  input  wire           rdBeatValid_i,
  input  wire           rdLast_i,
  input  wire wordT     rdBeat_i,
  // bus write side
  output logic          wrReq_o,
  output addrT          wrAddr_o,
  output lineT          wrLine_o,
  input  wire           wrGnt_i
);

  indexT   index;
  tagT     tag;
  wordSelT wordSel;
  logic    victimWay;
  wayVecT  storeEn;
  wayVecT  fillEn;
  wordT    storeWord;
  byteMaskT storeMask;
  lineT    fillLine;

  // per-way results
  wayVecT              wayHits;
  lineT [`DC_WAYS-1:0] wayLines;
  tagT [`DC_WAYS-1:0]  wayTags;
  wayVecT              wayDirty;

  // merged results
  wayVecT hitVec;
  logic   anyHit;
  logic   victimDirty;
  tagT    victimTag;
  lineT   victimLine;

  cacheCtrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqWrite_i    (reqWrite_i),
    .addr_i        (addr_i),
    .wrData_i      (wrData_i),
    .wrMask_i      (wrMask_i),
    .anyHit_i      (anyHit),
    .hitVec_i      (hitVec),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .victimLine_i  (victimLine),
    .rdGnt_i       (rdGnt_i),
    .rdBeatValid_i (rdBeatValid_i),
    .rdLast_i      (rdLast_i),
    .rdBeat_i      (rdBeat_i),
    .wrGnt_i       (wrGnt_i),
    .ready_o       (ready_o),
    .rdValid_o     (rdValid_o),
    .index_o       (index),
    .tag_o         (tag),
    .wordSel_o     (wordSel),
    .victimWay_o   (victimWay),
    .storeEn_o     (storeEn),
    .fillEn_o      (fillEn),
    .storeWord_o   (storeWord),
    .storeMask_o   (storeMask),
    .fillLine_o    (fillLine),
    .rdReq_o       (rdReq_o),
    .rdAddr_o      (rdAddr_o),
    .wrReq_o       (wrReq_o),
    .wrAddr_o      (wrAddr_o),
    .wrLine_o      (wrLine_o)
  );

  for (genvar g = 0; g < `DC_WAYS; g++) begin : gWay
    cacheWay u_way (
      .clk         (clk),
      .rst_n       (rst_n),
      .index_i     (index),
      .tag_i       (tag),
      .wordSel_i   (wordSel),
      .storeEn_i   (storeEn[g]),
      .storeWord_i (storeWord),
      .storeMask_i (storeMask),
      .fillEn_i    (fillEn[g]),
      .fillLine_i  (fillLine),
      .hit_o       (wayHits[g]),
      .line_o      (wayLines[g]),
      .tag_o       (wayTags[g]),
      .dirty_o     (wayDirty[g])
    );
  end

  wayMerge u_merge (
    .hitVec_i      (wayHits),
    .lines_i       (wayLines),
    .tags_i        (wayTags),
    .dirtyBits_i   (wayDirty),
    .victimWay_i   (victimWay),
    .wordSel_i     (wordSel),
    .hitVec_o      (hitVec),
    .anyHit_o      (anyHit),
    .rdData_o      (rdData_o),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag),
    .victimLine_o  (victimLine)
  );

endmodule

`default_nettype wire

/* sim/busMemory.sv */
`default_nettype none
`include "dcache_consts.svh"

module busMemory
  import cachePkg::*, busPkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  // random back-pressure, one bit per cycle
  input  wire       stall_i,
  input  wire       rdReq_i,
  input  wire addrT rdAddr_i,
  output logic      rdGnt_o,
  output logic      rdBeatValid_o,
  output logic      rdLast_o,
  output wordT      rdBeat_o,
  input  wire       wrReq_i,
  input  wire addrT wrAddr_i,
  input  wire lineT wrLine_i,
  output logic      wrGnt_o
);

  // sparse storage, keyed by word address
  wordT    mem [addrT];
  addrT    burstAddr;
  logic    bursting;
  wordSelT beatNum;

  function automatic wordT readWord(input addrT a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    // unwritten words hold a pattern of their own address
    return {~a, a};
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdGnt_o <= 1'b0;
      rdBeatValid_o <= 1'b0;
      rdLast_o <= 1'b0;
      rdBeat_o <= '0;
      wrGnt_o <= 1'b0;
      bursting <= 1'b0;
      burstAddr <= '0;
      beatNum <= '0;
    end else begin
      // grants are one-cycle strobes
      wrGnt_o <= wrReq_i && !wrGnt_o && !stall_i;
      rdGnt_o <= rdReq_i && !rdGnt_o && !bursting && !stall_i;
      if (rdReq_i && !rdGnt_o && !bursting && !stall_i) begin
        bursting <= 1'b1;
        burstAddr <= rdAddr_i;
        beatNum <= '0;
      end
      rdBeatValid_o <= 1'b0;
      rdLast_o <= 1'b0;
      // a stalled cycle leaves a gap between beats
      if (bursting && !stall_i) begin
        rdBeatValid_o <= 1'b1;
        rdBeat_o <= readWord(burstAddr + {27'b0, beatNum, 3'b000});
        rdLast_o <= (beatNum == 2'd3);
        beatNum <= beatNum + 2'd1;
        if (beatNum == 2'd3) begin
          bursting <= 1'b0;
        end
      end
    end
  end

  // line lands in memory on the granted edge
  always @(posedge clk) begin
    if (wrReq_i && wrGnt_o) begin
      for (int b = 0; b < `DC_BEATS; b++) begin
        mem[wrAddr_i + addrT'(b * 8)] = wrLine_i[b*`DC_XLEN +: `DC_XLEN];
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tbDcache.sv */
`default_nettype none
`include "dcache_consts.svh"

module tbDcache
  import cachePkg::*, busPkg::*;
();

  localparam int period = 40;
  localparam int numTests = 400;
  // generous bound on cycles for one miss with a dirty victim
  localparam int missBudget = 64;
  localparam logic [31:0] lfsrSeed = 32'hc47c;

  logic     clk;
  logic     rst_n;
  logic     reqValid;
  logic     reqWrite;
  addrT     addr;
  wordT     wrData;
  byteMaskT wrMask;
  logic     ready;
  logic     rdValid;
  wordT     rdData;
  logic     rdReq;
  addrT     rdAddr;
  logic     rdGnt;
  logic     rdBeatValid;
  logic     rdLast;
  wordT     rdBeat;
  logic     wrReq;
  addrT     wrAddr;
  lineT     wrLine;
  logic     wrGnt;
  logic     busStall;

  // reference model with the tag state of both ways and the memory as the cpu sees it
  logic mValid [`DC_WAYS][`DC_SETS];
  logic mDirty [`DC_WAYS][`DC_SETS];
  tagT  mTag [`DC_WAYS][`DC_SETS];
  logic mToggle;
  wordT gold [addrT];

  logic [31:0] lfsrState;
  int errors;
  int loads;
  int stores;
  int misses;
  int writeBacks;

  dcacheTop dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid),
    .reqWrite_i    (reqWrite),
    .addr_i        (addr),
    .wrData_i      (wrData),
    .wrMask_i      (wrMask),
    .ready_o       (ready),
    .rdValid_o     (rdValid),
    .rdData_o      (rdData),
    .rdReq_o       (rdReq),
    .rdAddr_o      (rdAddr),
    .rdGnt_i       (rdGnt),
    .rdBeatValid_i (rdBeatValid),
    .rdLast_i      (rdLast),
    .rdBeat_i      (rdBeat),
    .wrReq_o       (wrReq),
    .wrAddr_o      (wrAddr),
    .wrLine_o      (wrLine),
    .wrGnt_i       (wrGnt)
  );

  busMemory u_bus (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (busStall),
    .rdReq_i       (rdReq),
    .rdAddr_i      (rdAddr),
    .rdGnt_o       (rdGnt),
    .rdBeatValid_o (rdBeatValid),
    .rdLast_o      (rdLast),
    .rdBeat_o      (rdBeat),
    .wrReq_i       (wrReq),
    .wrAddr_i      (wrAddr),
    .wrLine_i      (wrLine),
    .wrGnt_o       (wrGnt)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic randBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
      lfsrState = lfsrState ^ 32'h8020_0003;
    end
    return outBit;
  endfunction

  function automatic logic [63:0] randBits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], randBit()};
    end
    return r;
  endfunction

  function automatic wordT memWord(input addrT a);
    if (gold.exists(a)) begin
      return gold[a];
    end
    return {~a, a};
  endfunction

  function automatic lineT memLine(input addrT lineAddr);
    lineT l;
    for (int b = 0; b < `DC_BEATS; b++) begin
      l[b*`DC_XLEN +: `DC_XLEN] = memWord(lineAddr + addrT'(b * 8));
    end
    return l;
  endfunction

  function automatic wordT applyMask(input wordT oldW, input wordT newW, input byteMaskT m);
    wordT w;
    w = oldW;
    for (int b = 0; b < 8; b++) begin
      if (m[b]) begin
        w[b*8 +: 8] = newW[b*8 +: 8];
      end
    end
    return w;
  endfunction

  task automatic reportMismatch(input string sigName, input logic [255:0] got,
                                input logic [255:0] exp);
    $display("** Error @%0t: %s = %0h, expected %0h", $time, sigName, got, exp);
    errors++;
  endtask

  task automatic reportFailure(input string what);
    $display("Failure at time %0t: %s", $time, what);
    errors++;
  endtask

  // one request from acceptance to completion
  task automatic runOp();
    logic [63:0] rnd;
    logic     isWrite;
    tagT      tag;
    indexT    idx;
    wordSelT  ws;
    addrT     a;
    addrT     lineAddr;
    addrT     victimAddr;
    wordT     data;
    byteMaskT mask;
    wordT     expWord;
    logic     expHit;
    logic     wayIdx;
    logic     victim;
    logic     expWb;
    int       k;
    int       beatIdx;
    int       rdPulses;
    logic     sawRdReq;
    logic     sawWrReq;
    logic     done;

    @(negedge clk);
    rnd = randBits(1);
    isWrite = rnd[0];
    // four tags over four sets keep the two ways busy
    rnd = randBits(2);
    tag = {rnd[1:0], 19'h2b1c3};
    rnd = randBits(2);
    idx = {rnd[1:0], 4'b1001};
    rnd = randBits(2);
    ws = rnd[1:0];
    data = randBits(64);
    rnd = randBits(8);
    mask = rnd[7:0];
    a = {tag, idx, ws, 3'b000};
    lineAddr = {tag, idx, 5'b00000};
    expWord = memWord(a);

    expHit = 1'b0;
    wayIdx = 1'b0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (mValid[w][idx] && mTag[w][idx] == tag) begin
        expHit = 1'b1;
        wayIdx = w[0];
      end
    end
    victim = mToggle;
    expWb = !expHit && mValid[victim][idx] && mDirty[victim][idx];
    victimAddr = {mTag[victim][idx], idx, 5'b00000};

    @(posedge clk);
    reqValid <= 1'b1;
    reqWrite <= isWrite;
    addr <= a;
    wrData <= data;
    wrMask <= mask;
    @(posedge clk);
    reqValid <= 1'b0;

    k = 0;
    beatIdx = 0;
    rdPulses = 0;
    sawRdReq = 1'b0;
    sawWrReq = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      k++;
      if (k == 1 && ready) begin
        reportFailure("ready_o high during lookup");
      end
      if (rdValid) begin
        rdPulses++;
        if (rdData !== expWord) begin
          reportMismatch("rdData_o", 256'(rdData), 256'(expWord));
        end
      end
      // address and line must hold steady while the grant is missing
      if (wrReq) begin
        sawWrReq = 1'b1;
        if (expWb && wrAddr !== victimAddr) begin
          reportMismatch("wrAddr_o", 256'(wrAddr), 256'(victimAddr));
        end
        if (expWb && wrLine !== memLine(victimAddr)) begin
          reportMismatch("wrLine_o", wrLine, memLine(victimAddr));
        end
      end
      if (rdReq) begin
        sawRdReq = 1'b1;
        if (rdAddr !== lineAddr) begin
          reportMismatch("rdAddr_o", 256'(rdAddr), 256'(lineAddr));
        end
      end
      if (rdBeatValid) begin
        if (rdBeat !== memWord(lineAddr + addrT'(beatIdx * 8))) begin
          reportMismatch("rdBeat_i", 256'(rdBeat),
                         256'(memWord(lineAddr + addrT'(beatIdx * 8))));
        end
        beatIdx++;
      end
      if (ready && k > 1) begin
        done = 1'b1;
      end
    end

    if (isWrite && rdPulses != 0) begin
      reportFailure("rdValid_o pulsed for a store");
    end
    if (!isWrite && rdPulses != 1) begin
      reportFailure("load did not give exactly one rdValid_o pulse");
    end
    if (expHit && (sawRdReq || k != 2)) begin
      reportFailure("expected hit did not complete in one lookup cycle");
    end
    if (!expHit && !sawRdReq) begin
      reportFailure("expected miss produced no refill request");
    end
    if (sawWrReq != expWb) begin
      reportFailure("write-back presence differs from the victim's dirty state");
    end

    if (!expHit) begin
      misses++;
      mToggle = ~mToggle;
      mValid[victim][idx] = 1'b1;
      mDirty[victim][idx] = 1'b0;
      mTag[victim][idx] = tag;
      wayIdx = victim;
    end
    if (expWb) begin
      writeBacks++;
    end
    if (isWrite) begin
      stores++;
      mDirty[wayIdx][idx] = 1'b1;
      gold[a] = applyMask(expWord, data, mask);
    end else begin
      loads++;
    end
  endtask

  // bus back-pressure drawn on rising edges only
  initial begin
    busStall = 1'b0;
    forever begin
      @(posedge clk);
      busStall <= randBit();
    end
  end

  initial begin
    #(period * (5 + numTests * missBudget));
    $display("watchdog expired, the run did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    lfsrState = lfsrSeed;
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    addr = '0;
    wrData = '0;
    wrMask = '0;
    mToggle = 1'b0;
    errors = 0;
    loads = 0;
    stores = 0;
    misses = 0;
    writeBacks = 0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        mValid[w][s] = 1'b0;
        mDirty[w][s] = 1'b0;
        mTag[w][s] = '0;
      end
    end

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      if (!ready || rdValid || rdReq || wrReq) begin
        reportFailure("cpu or bus outputs not idle after reset");
      end
    end

    for (int t = 0; t < numTests; t++) begin
      runOp();
    end

    @(negedge clk);
    $display("ops %0d, loads %0d, stores %0d, misses %0d, write-backs %0d, errors %0d",
             numTests, loads, stores, misses, writeBacks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/cachePkg.sv
src/busPkg.sv
src/cacheCtrl.sv
src/cacheWay.sv
src/wayMerge.sv
src/dcacheTop.sv
sim/busMemory.sv
sim/tbDcache.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbDcache -f build.f -o simDcache &&
./obj_dir/simDcache | tee /dev/stderr | grep -q -F -- '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
